// File: common/afu_pkg.sv
// Shared definitions for the accelerator bus control core
// Command and response lines, response codes and field sizes

package afu_pkg;

	////////////////////////////////////////////////////////////
	// Field sizes
	////////////////////////////////////////////////////////////

	localparam int TAG_W  = 8;
	localparam int ADDR_W = 32;
	localparam int CU_W   = 4;

	typedef enum logic {
		CMD_READ  = 1'b0,
		CMD_WRITE = 1'b1
	} cmd_class_t;

	// Bus response codes, anything but DONE is an error
	typedef enum logic [2:0] {
		DONE    = 3'd0,
		AERROR  = 3'd1,
		DERROR  = 3'd2,
		PAGED   = 3'd3,
		FAULT   = 3'd4,
		FLUSHED = 3'd5,
		FAILED  = 3'd6
	} rsp_code_t;

	////////////////////////////////////////////////////////////
	// Lines moving through the core
	////////////////////////////////////////////////////////////

	// Tag is filled in at issue
	typedef struct packed {
		logic              valid;
		cmd_class_t        cmd_type;
		logic [ADDR_W-1:0] address;
		logic [CU_W-1:0]   cu_id;
		logic [TAG_W-1:0]  tag;
	} cmd_line_t;

	typedef struct packed {
		logic             valid;
		logic [TAG_W-1:0] tag;
		rsp_code_t        code;
	} rsp_in_t;

	typedef struct packed {
		logic             valid;
		logic [TAG_W-1:0] tag;
		rsp_code_t        code;
		cmd_class_t       cmd_type;
		logic             is_error;
	} rsp_line_t;

	// Sticky, one bit per error kind
	typedef struct packed {
		logic aerror;
		logic derror;
		logic paged;
		logic flushed;
		logic failed;
	} err_flags_t;

	typedef struct packed {
		logic empty;
		logic full;
	} queue_status_t;

endpackage

// File: src/sync_fifo.sv
// Synchronous first-word-fall-through queue
// Circular buffer, oldest entry always shown on head

`timescale 1ns/1ps

module sync_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  DEPTH     = 4
) (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   push,
	input  payload_t               data_in,
	input  logic                   pop,
	output payload_t               head,
	output afu_pkg::queue_status_t status
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t         mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	assign status.empty = (count == '0);
	assign status.full  = (count == CNT_W'(DEPTH));

	// Overflow and underflow are dropped
	assign do_push = push && !status.full;
	assign do_pop  = pop && !status.empty;
	assign head    = mem[rd_ptr];

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: command/command_issue.sv
// Command issue stage
// Round-robin pick between the read and write queue heads,
// bus credit counting and the two-stage command output register

`timescale 1ns/1ps

module command_issue #(
	parameter int CREDITS = 6
) (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         enabled,
	input  afu_pkg::cmd_line_t           read_head,
	input  afu_pkg::cmd_line_t           write_head,
	input  afu_pkg::queue_status_t       read_status,
	input  afu_pkg::queue_status_t       write_status,
	input  logic                         tag_free,
	input  logic [afu_pkg::TAG_W-1:0]    free_tag,
	input  logic                         credit_return,
	output logic                         read_pop,
	output logic                         write_pop,
	output logic                         alloc,
	output afu_pkg::cmd_line_t           command_out
);

	localparam int CRED_W = $clog2(CREDITS + 1);

	logic [CRED_W-1:0]   credits;
	afu_pkg::cmd_class_t last_class;
	afu_pkg::cmd_line_t  next_line;
	afu_pkg::cmd_line_t  chosen;
	logic                can_issue;
	logic                read_ok;
	logic                write_ok;
	logic                pick_write;

	////////////////////////////////////////////////////////////
	// Arbitration
	////////////////////////////////////////////////////////////

	assign can_issue = enabled && (credits != '0) && tag_free;
	assign read_ok   = can_issue && !read_status.empty;
	assign write_ok  = can_issue && !write_status.empty;

	// On a tie the class not served last wins
	assign pick_write = write_ok && (!read_ok || (last_class == afu_pkg::CMD_READ));
	assign write_pop  = pick_write;
	assign read_pop   = read_ok && !pick_write;
	assign alloc      = read_pop || write_pop;

	always_comb begin
		next_line          = pick_write ? write_head : read_head;
		next_line.cmd_type = pick_write ? afu_pkg::CMD_WRITE : afu_pkg::CMD_READ;
		next_line.tag      = free_tag;
		next_line.valid    = alloc;
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			last_class <= afu_pkg::CMD_WRITE;
		end else if (alloc) begin
			last_class <= next_line.cmd_type;
		end
	end

	////////////////////////////////////////////////////////////
	// Credits
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			credits <= CRED_W'(CREDITS);
		end else begin
			case ({alloc, credit_return})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	// Chosen command waits here while disabled
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			chosen      <= '0;
			command_out <= '0;
		end else if (enabled) begin
			command_out <= chosen;
			chosen      <= next_line;
		end else begin
			command_out <= '0;
		end
	end

endmodule

// File: command/tag_control.sv
// Tag allocation and tag table
// Hands out the lowest free tag, remembers each tag's command class
// and frees the tag when its response is routed

`timescale 1ns/1ps

module tag_control #(
	parameter int NUM_TAGS = 8
) (
	input  logic                      clock,
	input  logic                      rstn,
	input  logic                      alloc,
	input  afu_pkg::cmd_class_t       alloc_class,
	input  logic                      release_valid,
	input  logic [afu_pkg::TAG_W-1:0] release_tag,
	input  logic [afu_pkg::TAG_W-1:0] lookup_tag,
	output afu_pkg::cmd_class_t       lookup_class,
	output logic                      tag_free,
	output logic [afu_pkg::TAG_W-1:0] free_tag
);

	localparam int IDX_W = (NUM_TAGS > 1) ? $clog2(NUM_TAGS) : 1;

	logic [NUM_TAGS-1:0] busy;
	afu_pkg::cmd_class_t class_table [NUM_TAGS];
	logic [IDX_W-1:0]    alloc_idx;
	logic [IDX_W-1:0]    release_idx;
	logic [IDX_W-1:0]    lookup_idx;

	assign alloc_idx   = free_tag[IDX_W-1:0];
	assign release_idx = release_tag[IDX_W-1:0];
	assign lookup_idx  = lookup_tag[IDX_W-1:0];

	// Priority search, the loop runs downward so the lowest index wins
	always_comb begin
		tag_free = 1'b0;
		free_tag = '0;
		for (int i = NUM_TAGS - 1; i >= 0; i--) begin
			if (!busy[i]) begin
				tag_free = 1'b1;
				free_tag = afu_pkg::TAG_W'(i);
			end
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			busy <= '0;
		end else begin
			if (alloc && tag_free) begin
				busy[alloc_idx] <= 1'b1;
			end
			if (release_valid) begin
				busy[release_idx] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (alloc && tag_free) begin
			class_table[alloc_idx] <= alloc_class;
		end
	end

	// Class of the outstanding command, read by the decoder
	assign lookup_class = class_table[lookup_idx];

endmodule

// File: response/response_decode.sv
// Response decode
// Latches bus responses, classifies the code, adds the command class
// from the tag table and keeps the sticky error flags

`timescale 1ns/1ps

module response_decode (
	input  logic                      clock,
	input  logic                      rstn,
	input  logic                      enabled,
	input  afu_pkg::rsp_in_t          response_in,
	input  afu_pkg::cmd_class_t       lookup_class,
	output logic [afu_pkg::TAG_W-1:0] lookup_tag,
	output afu_pkg::rsp_line_t        decoded,
	output afu_pkg::err_flags_t       response_error
);

	afu_pkg::rsp_in_t response_q;

	// Bus side latch, dropped while disabled
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			response_q <= '0;
		end else if (enabled) begin
			response_q <= response_in;
		end else begin
			response_q <= '0;
		end
	end

	assign lookup_tag = response_q.tag;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			decoded <= '0;
		end else begin
			decoded.valid    <= response_q.valid;
			decoded.tag      <= response_q.tag;
			decoded.code     <= response_q.code;
			decoded.cmd_type <= lookup_class;
			decoded.is_error <= (response_q.code != afu_pkg::DONE);
		end
	end

	////////////////////////////////////////////////////////////
	// Sticky error flags
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			response_error <= '0;
		end else if (response_q.valid) begin
			case (response_q.code)
				afu_pkg::AERROR: response_error.aerror <= 1'b1;
				afu_pkg::DERROR: response_error.derror <= 1'b1;
				afu_pkg::PAGED,
				afu_pkg::FAULT: response_error.paged <= 1'b1;
				afu_pkg::FLUSHED: response_error.flushed <= 1'b1;
				afu_pkg::FAILED: response_error.failed <= 1'b1;
				default: ;
			endcase
		end
	end

endmodule

// File: response/response_route.sv
// Response routing
// Sorts decoded responses into read and write buffers, frees the tag,
// returns one credit per response and drains each buffer once a cycle

`timescale 1ns/1ps

module response_route #(
	parameter int RSP_DEPTH = 4
) (
	input  logic                      clock,
	input  logic                      rstn,
	input  afu_pkg::rsp_line_t        decoded,
	output afu_pkg::rsp_line_t        read_response_out,
	output afu_pkg::rsp_line_t        write_response_out,
	output logic                      credit_return,
	output logic                      release_valid,
	output logic [afu_pkg::TAG_W-1:0] release_tag
);

	afu_pkg::rsp_line_t     read_head;
	afu_pkg::rsp_line_t     write_head;
	afu_pkg::queue_status_t read_status;
	afu_pkg::queue_status_t write_status;
	logic                   read_push;
	logic                   write_push;

	assign read_push  = decoded.valid && (decoded.cmd_type == afu_pkg::CMD_READ);
	assign write_push = decoded.valid && (decoded.cmd_type == afu_pkg::CMD_WRITE);

	// Tag is free as soon as the line is buffered
	assign release_valid = decoded.valid;
	assign release_tag   = decoded.tag;

	sync_fifo #(.payload_t(afu_pkg::rsp_line_t), .DEPTH(RSP_DEPTH)) read_buffer (
		.clock  (clock),
		.rstn   (rstn),
		.push   (read_push),
		.data_in(decoded),
		.pop    (!read_status.empty),
		.head   (read_head),
		.status (read_status)
	);

	sync_fifo #(.payload_t(afu_pkg::rsp_line_t), .DEPTH(RSP_DEPTH)) write_buffer (
		.clock  (clock),
		.rstn   (rstn),
		.push   (write_push),
		.data_in(decoded),
		.pop    (!write_status.empty),
		.head   (write_head),
		.status (write_status)
	);

	// Drain registers and credit pulse
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			read_response_out  <= '0;
			write_response_out <= '0;
			credit_return      <= 1'b0;
		end else begin
			read_response_out  <= read_status.empty ? '0 : read_head;
			write_response_out <= write_status.empty ? '0 : write_head;
			credit_return      <= decoded.valid;
		end
	end

endmodule

// File: src/afu_control_top.sv
// Accelerator bus control core, top level
// Command queues and issue with tags and credits on one side,
// response decode and routing back to the compute units on the other

`timescale 1ns/1ps

module afu_control_top #(
	parameter int NUM_TAGS  = 8,
	parameter int CREDITS   = 6,
	parameter int CMD_DEPTH = 4,
	parameter int RSP_DEPTH = 4
) (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   enabled_in,
	input  afu_pkg::cmd_line_t     read_command_in,
	input  afu_pkg::cmd_line_t     write_command_in,
	input  afu_pkg::rsp_in_t       response_in,
	output afu_pkg::cmd_line_t     command_out,
	output afu_pkg::rsp_line_t     read_response_out,
	output afu_pkg::rsp_line_t     write_response_out,
	output afu_pkg::err_flags_t    response_error,
	output afu_pkg::queue_status_t read_queue_status,
	output afu_pkg::queue_status_t write_queue_status
);

	logic                      enabled;
	afu_pkg::cmd_line_t        read_head;
	afu_pkg::cmd_line_t        write_head;
	logic                      read_pop;
	logic                      write_pop;
	logic                      alloc;
	logic                      tag_free;
	logic [afu_pkg::TAG_W-1:0] free_tag;
	logic [afu_pkg::TAG_W-1:0] lookup_tag;
	logic [afu_pkg::TAG_W-1:0] release_tag;
	afu_pkg::cmd_class_t       lookup_class;
	afu_pkg::rsp_line_t        decoded;
	logic                      credit_return;
	logic                      release_valid;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled <= 1'b0;
		end else begin
			enabled <= enabled_in;
		end
	end

	////////////////////////////////////////////////////////////
	// Command side
	////////////////////////////////////////////////////////////

	sync_fifo #(.payload_t(afu_pkg::cmd_line_t), .DEPTH(CMD_DEPTH)) read_cmd_queue (
		.clock  (clock),
		.rstn   (rstn),
		.push   (read_command_in.valid),
		.data_in(read_command_in),
		.pop    (read_pop),
		.head   (read_head),
		.status (read_queue_status)
	);

	sync_fifo #(.payload_t(afu_pkg::cmd_line_t), .DEPTH(CMD_DEPTH)) write_cmd_queue (
		.clock  (clock),
		.rstn   (rstn),
		.push   (write_command_in.valid),
		.data_in(write_command_in),
		.pop    (write_pop),
		.head   (write_head),
		.status (write_queue_status)
	);

	command_issue #(.CREDITS(CREDITS)) issue (
		.clock        (clock),
		.rstn         (rstn),
		.enabled      (enabled),
		.read_head    (read_head),
		.write_head   (write_head),
		.read_status  (read_queue_status),
		.write_status (write_queue_status),
		.tag_free     (tag_free),
		.free_tag     (free_tag),
		.credit_return(credit_return),
		.read_pop     (read_pop),
		.write_pop    (write_pop),
		.alloc        (alloc),
		.command_out  (command_out)
	);

	// Class follows the queue that was popped
	tag_control #(.NUM_TAGS(NUM_TAGS)) tags (
		.clock        (clock),
		.rstn         (rstn),
		.alloc        (alloc),
		.alloc_class  (write_pop ? afu_pkg::CMD_WRITE : afu_pkg::CMD_READ),
		.release_valid(release_valid),
		.release_tag  (release_tag),
		.lookup_tag   (lookup_tag),
		.lookup_class (lookup_class),
		.tag_free     (tag_free),
		.free_tag     (free_tag)
	);

	////////////////////////////////////////////////////////////
	// Response side
	////////////////////////////////////////////////////////////

	response_decode decode (
		.clock         (clock),
		.rstn          (rstn),
		.enabled       (enabled),
		.response_in   (response_in),
		.lookup_class  (lookup_class),
		.lookup_tag    (lookup_tag),
		.decoded       (decoded),
		.response_error(response_error)
	);

	response_route #(.RSP_DEPTH(RSP_DEPTH)) route (
		.clock             (clock),
		.rstn              (rstn),
		.decoded           (decoded),
		.read_response_out (read_response_out),
		.write_response_out(write_response_out),
		.credit_return     (credit_return),
		.release_valid     (release_valid),
		.release_tag       (release_tag)
	);

endmodule

// File: bench/afu_control_sva.sv
// Assertion checker bound into the control core top level
// Shadow tag table, expected codes, class order, queue levels and credit count

`timescale 1ns/1ps

module afu_control_sva #(
	parameter int NUM_TAGS  = 8,
	parameter int CREDITS   = 6,
	parameter int CMD_DEPTH = 4
) (
	input logic                   clock,
	input logic                   rstn,
	input logic                   enabled,
	input logic                   alloc,
	input logic                   write_pop,
	input afu_pkg::cmd_line_t     read_command_in,
	input afu_pkg::cmd_line_t     write_command_in,
	input afu_pkg::rsp_in_t       response_in,
	input afu_pkg::cmd_line_t     command_out,
	input afu_pkg::rsp_line_t     decoded,
	input afu_pkg::rsp_line_t     read_response_out,
	input afu_pkg::rsp_line_t     write_response_out,
	input afu_pkg::err_flags_t    response_error,
	input afu_pkg::queue_status_t read_queue_status,
	input afu_pkg::queue_status_t write_queue_status
);

	logic [NUM_TAGS-1:0] out_busy;
	afu_pkg::cmd_class_t tag_class [NUM_TAGS];
	afu_pkg::rsp_code_t  exp_code [NUM_TAGS];
	afu_pkg::err_flags_t seen;
	afu_pkg::cmd_class_t last_class;
	logic                served;
	logic [31:0]         read_exp [64];
	logic [31:0]         write_exp [64];
	int                  read_in;
	int                  read_out;
	int                  write_in;
	int                  write_out;
	int                  read_level;
	int                  write_level;
	int                  outstanding;
	int                  failures = 0;

	function automatic afu_pkg::err_flags_t err_bit(input afu_pkg::rsp_code_t code);
		afu_pkg::err_flags_t f;
		f         = '0;
		f.aerror  = (code == afu_pkg::AERROR);
		f.derror  = (code == afu_pkg::DERROR);
		f.paged   = (code == afu_pkg::PAGED) || (code == afu_pkg::FAULT);
		f.flushed = (code == afu_pkg::FLUSHED);
		f.failed  = (code == afu_pkg::FAILED);
		return f;
	endfunction

	function automatic int idx(input logic [afu_pkg::TAG_W-1:0] tag);
		return int'(tag) % NUM_TAGS;
	endfunction

	////////////////////////////////////////////////////////////
	// Shadow state
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			out_busy    <= '0;
			seen        <= '0;
			served      <= 1'b0;
			last_class  <= afu_pkg::CMD_READ;
			read_in     <= 0;
			read_out    <= 0;
			write_in    <= 0;
			write_out   <= 0;
			read_level  <= 0;
			write_level <= 0;
			outstanding <= 0;
		end else begin
			if (read_command_in.valid) begin
				read_exp[read_in % 64] <= read_command_in.address;
				read_in <= read_in + 1;
			end
			if (write_command_in.valid) begin
				write_exp[write_in % 64] <= write_command_in.address;
				write_in <= write_in + 1;
			end
			if (command_out.valid) begin
				out_busy[idx(command_out.tag)]  <= 1'b1;
				tag_class[idx(command_out.tag)] <= command_out.cmd_type;
				if (command_out.cmd_type == afu_pkg::CMD_READ) begin
					read_out <= read_out + 1;
				end else begin
					write_out <= write_out + 1;
				end
			end
			if (decoded.valid) begin
				out_busy[idx(decoded.tag)] <= 1'b0;
			end
			if (enabled && response_in.valid) begin
				exp_code[idx(response_in.tag)] <= response_in.code;
				seen <= seen | err_bit(response_in.code);
			end
			if (alloc) begin
				served     <= 1'b1;
				last_class <= write_pop ? afu_pkg::CMD_WRITE : afu_pkg::CMD_READ;
			end
			// Queue occupancy from pushes and pops
			read_level  <= read_level + int'(read_command_in.valid)
				- int'(alloc && !write_pop);
			write_level <= write_level + int'(write_command_in.valid) - int'(write_pop);
			// Commands on the bus still waiting for their response
			outstanding <= outstanding + int'(command_out.valid) - int'(decoded.valid);
		end
	end

	////////////////////////////////////////////////////////////
	// Assertions
	////////////////////////////////////////////////////////////

	a_push_read: assert property (@(posedge clock) disable iff (!rstn)
		read_command_in.valid |-> !read_queue_status.full)
		else begin failures++; $error("read push while full"); end

	a_push_write: assert property (@(posedge clock) disable iff (!rstn)
		write_command_in.valid |-> !write_queue_status.full)
		else begin failures++; $error("write push while full"); end

	a_read_level: assert property (@(posedge clock) disable iff (!rstn)
		read_queue_status.empty == (read_level == 0)
			&& read_queue_status.full == (read_level == CMD_DEPTH))
		else begin failures++; $error("read queue status does not match its level"); end

	a_write_level: assert property (@(posedge clock) disable iff (!rstn)
		write_queue_status.empty == (write_level == 0)
			&& write_queue_status.full == (write_level == CMD_DEPTH))
		else begin failures++; $error("write queue status does not match its level"); end

	a_tag_free: assert property (@(posedge clock) disable iff (!rstn)
		command_out.valid |-> (int'(command_out.tag) < NUM_TAGS)
			&& !out_busy[idx(command_out.tag)])
		else begin failures++; $error("command issued with busy tag"); end

	a_read_order: assert property (@(posedge clock) disable iff (!rstn)
		command_out.valid && command_out.cmd_type == afu_pkg::CMD_READ
			|-> read_out < read_in && command_out.address == read_exp[read_out % 64])
		else begin failures++; $error("read command out of order"); end

	a_write_order: assert property (@(posedge clock) disable iff (!rstn)
		command_out.valid && command_out.cmd_type == afu_pkg::CMD_WRITE
			|-> write_out < write_in && command_out.address == write_exp[write_out % 64])
		else begin failures++; $error("write command out of order"); end

	a_alternate: assert property (@(posedge clock) disable iff (!rstn)
		alloc && served && !read_queue_status.empty && !write_queue_status.empty
			|-> write_pop == (last_class == afu_pkg::CMD_READ))
		else begin failures++; $error("round-robin did not alternate"); end

	a_credits: assert property (@(posedge clock) disable iff (!rstn)
		outstanding <= CREDITS)
		else begin failures++; $error("more commands outstanding than credits"); end

	a_read_rsp: assert property (@(posedge clock) disable iff (!rstn)
		read_response_out.valid |-> tag_class[idx(read_response_out.tag)] == afu_pkg::CMD_READ
			&& read_response_out.code == exp_code[idx(read_response_out.tag)]
			&& read_response_out.is_error == (read_response_out.code != afu_pkg::DONE)
			&& !out_busy[idx(read_response_out.tag)]
			&& (response_error & err_bit(read_response_out.code))
				== err_bit(read_response_out.code))
		else begin failures++; $error("read response mismatch"); end

	a_write_rsp: assert property (@(posedge clock) disable iff (!rstn)
		write_response_out.valid |-> tag_class[idx(write_response_out.tag)] == afu_pkg::CMD_WRITE
			&& write_response_out.code == exp_code[idx(write_response_out.tag)]
			&& write_response_out.is_error == (write_response_out.code != afu_pkg::DONE)
			&& !out_busy[idx(write_response_out.tag)]
			&& (response_error & err_bit(write_response_out.code))
				== err_bit(write_response_out.code))
		else begin failures++; $error("write response mismatch"); end

	a_err_seen: assert property (@(posedge clock) disable iff (!rstn)
		(response_error & ~seen) == '0)
		else begin failures++; $error("error flag set without a matching response"); end

	a_err_sticky: assert property (@(posedge clock) disable iff (!rstn)
		($past(response_error) & ~response_error) == '0)
		else begin failures++; $error("error flag cleared"); end

	a_off_cmd: assert property (@(posedge clock) disable iff (!rstn)
		!enabled |=> !command_out.valid)
		else begin failures++; $error("command issued while disabled"); end

	a_off_rsp: assert property (@(posedge clock) disable iff (!rstn)
		!enabled |-> ##2 !decoded.valid)
		else begin failures++; $error("response accepted while disabled"); end

endmodule

bind afu_control_top afu_control_sva #(
	.NUM_TAGS (NUM_TAGS),
	.CREDITS  (CREDITS),
	.CMD_DEPTH(CMD_DEPTH)
) checks (.*);

// File: bench/afu_control_tb.sv
// Testbench for the accelerator bus control core
// Random command traffic, a bus model with random response delay,
// a disabled phase and a phase with withheld responses

`timescale 1ns/1ps

module afu_control_tb;

	localparam int CREDITS = 6;
	localparam int TOTAL   = 60;
	localparam int LIMIT   = TOTAL * 40;

	logic                   clock;
	logic                   rstn;
	logic                   enabled_in;
	afu_pkg::cmd_line_t     read_command_in;
	afu_pkg::cmd_line_t     write_command_in;
	afu_pkg::rsp_in_t       response_in;
	afu_pkg::cmd_line_t     command_out;
	afu_pkg::rsp_line_t     read_response_out;
	afu_pkg::rsp_line_t     write_response_out;
	afu_pkg::err_flags_t    response_error;
	afu_pkg::queue_status_t read_queue_status;
	afu_pkg::queue_status_t write_queue_status;

	logic [15:0] lfsr;
	int          cycle;
	int          pushed;
	int          issued;
	int          returned;
	int          stray_count;
	bit          hold;
	int          pend_tag[$];
	int          pend_due[$];

	afu_control_top DUT (.*);

	always #4 clock = ~clock;

	// Galois LFSR stepped once per bit taken
	function automatic logic [7:0] take_bits(input int n);
		logic [7:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[6:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		end
		return r;
	endfunction

	// Mostly DONE and sometimes one of the error codes
	function automatic afu_pkg::rsp_code_t pick_code();
		if (take_bits(3) < 5) begin
			return afu_pkg::DONE;
		end
		return afu_pkg::rsp_code_t'(3'(1 + (take_bits(3) % 6)));
	endfunction

	task automatic report_mismatch(input string name, input int expected, input int actual);
		$display("[FAIL] %s expected %0d actual %0d", name, expected, actual);
		$display("Simulation failed");
		$fatal(1, "check %s", name);
	endtask

	////////////////////////////////////////////////////////////
	// Bus model
	////////////////////////////////////////////////////////////

	// Answers one due tag per cycle
	// While on hold only stray responses go out
	task automatic drive_bus();
		int idx;
		idx = -1;
		response_in = '0;
		if (!hold) begin
			for (int i = 0; i < pend_tag.size(); i++) begin
				if (idx < 0 && pend_due[i] <= cycle) begin
					idx = i;
				end
			end
			if (idx >= 0) begin
				response_in.valid = 1'b1;
				response_in.tag   = afu_pkg::TAG_W'(pend_tag[idx]);
				response_in.code  = pick_code();
				pend_tag.delete(idx);
				pend_due.delete(idx);
			end
		end else if (stray_count > 0) begin
			response_in.valid = 1'b1;
			response_in.tag   = afu_pkg::TAG_W'(take_bits(3));
			response_in.code  = afu_pkg::FAILED;
			stray_count--;
		end
	endtask

	task automatic step();
		@(posedge clock);
		#1;
		drive_bus();
	endtask

	// Falls back to the other class when the chosen queue is full
	task automatic push_command(input bit want_write);
		afu_pkg::cmd_line_t line;
		while (read_queue_status.full && write_queue_status.full) begin
			step();
		end
		if (want_write && write_queue_status.full) begin
			want_write = 1'b0;
		end else if (!want_write && read_queue_status.full) begin
			want_write = 1'b1;
		end
		line          = '0;
		line.valid    = 1'b1;
		line.cmd_type = want_write ? afu_pkg::CMD_WRITE : afu_pkg::CMD_READ;
		line.address  = {take_bits(8), take_bits(8), take_bits(8), take_bits(8)};
		line.cu_id    = 4'(take_bits(4));
		if (want_write) begin
			write_command_in = line;
		end else begin
			read_command_in = line;
		end
		pushed++;
		step();
		read_command_in  = '0;
		write_command_in = '0;
	endtask

	task automatic wait_drain();
		while (returned != pushed) begin
			step();
		end
	endtask

	////////////////////////////////////////////////////////////
	// Monitor, timeout and assertion watch
	////////////////////////////////////////////////////////////

	always @(posedge clock) begin
		cycle++;
		if (cycle > LIMIT) begin
			$display("Timeout after %0d cycles with %0d of %0d responses back",
				cycle, returned, pushed);
			$display("Simulation failed");
			$fatal(1, "timeout");
		end else if (DUT.checks.failures != 0) begin
			$display("An assertion in the bound checker failed");
			$display("Simulation failed");
			$fatal(1, "assertion failure");
		end else if (rstn) begin
			if (command_out.valid) begin
				issued++;
				pend_tag.push_back(int'(command_out.tag));
				pend_due.push_back(cycle + int'(take_bits(3)));
			end
			if (read_response_out.valid) begin
				returned++;
			end
			if (write_response_out.valid) begin
				returned++;
			end
		end
	end

	initial begin
		lfsr             = 16'd13455;
		clock            = 1'b0;
		rstn             = 1'b0;
		enabled_in       = 1'b0;
		read_command_in  = '0;
		write_command_in = '0;
		response_in      = '0;
		cycle            = 0;
		pushed           = 0;
		issued           = 0;
		returned         = 0;
		stray_count      = 0;
		hold             = 1'b0;
		repeat (2) @(posedge clock);
		#1;
		rstn       = 1'b1;
		enabled_in = 1'b1;
		step();

		// Random mixed traffic
		for (int i = 0; i < 40; i++) begin
			push_command(take_bits(1) != 0);
			repeat (take_bits(2)) step();
		end
		wait_drain();

		// Disabled phase where commands wait and stray responses are dropped
		hold = 1'b1;
		repeat (2) step();
		enabled_in = 1'b0;
		repeat (3) step();
		for (int i = 0; i < 8; i++) begin
			push_command(take_bits(1) != 0);
		end
		stray_count = 3;
		repeat (10) step();
		if (issued != 40) begin
			report_mismatch("disabled_issue", 40, issued);
		end
		enabled_in = 1'b1;
		repeat (3) step();
		hold = 1'b0;
		wait_drain();

		// Withheld responses stop issue at the credit limit
		hold = 1'b1;
		for (int i = 0; i < 12; i++) begin
			push_command(take_bits(1) != 0);
		end
		repeat (20) step();
		if (issued - returned != CREDITS) begin
			report_mismatch("credit_limit", CREDITS, issued - returned);
		end
		hold = 1'b0;
		wait_drain();
		repeat (5) step();

		if (DUT.checks.failures != 0) begin
			$display("An assertion in the bound checker failed");
			$display("Simulation failed");
			$fatal(1, "assertion failure");
		end else if (issued == pushed && returned == pushed && pushed == TOTAL) begin
			$display("Simulation completed successfully");
			$finish;
		end else begin
			$display("[FAIL] final_counts expected %0d actual issued %0d returned %0d",
				TOTAL, issued, returned);
			$display("Simulation failed");
			$fatal(1, "final counts");
		end
	end

endmodule

// File: build.f
common/afu_pkg.sv
src/sync_fifo.sv
command/command_issue.sv
command/tag_control.sv
response/response_decode.sv
response/response_route.sv
src/afu_control_top.sv
bench/afu_control_sva.sv
bench/afu_control_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the control core simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module afu_control_tb -f build.f -o afu_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/afu_sim +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log

if [ $status -ne 0 ]; then
	echo "Simulator exited with status $status"
	exit 1
fi
if grep -q "Simulation failed" sim.log; then
	exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
	echo "No pass message in log"
	exit 1
fi
exit 0
